/* project.f */
hw/dispatch_pkg.sv
hw/gen_fifo.sv
hw/dispatch.sv
hw/iorder_buffer.sv
hw/dispatch_top.sv
testbench/tb_dispatch.sv

/* Makefile */
SIM      = verilator
TOP      = tb_dispatch
FILELIST = project.f
FLAGS    = --binary --timing --assert -j 0
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* testbench/tb_dispatch.sv */
/* tb_dispatch
 * directed and random tests of the dispatch stage, with the testbench acting as issue units. */

`timescale 1ns/1ps

module tb_dispatch import dispatch_pkg::*; ();

	localparam int DP         = 4;
	localparam int IORDER_DP  = 8;
	localparam int N_RANDOM   = 200;
	localparam int TIMEOUT_NS = 20000; // about twice the expected run.

	logic                 CLK;
	logic                 rst;
	logic                 in_valid;
	logic                 in_ready;
	micro_instr_t         in_instr;
	logic [UNIT_NUM-1:0]  issue_valid;
	logic [UNIT_NUM-1:0]  issue_ready;
	issue_info_t          issue_info;
	logic                 complete_valid;
	logic [TAG_W-1:0]     complete_tag;
	logic                 commit_valid;
	iorder_info_t         commit_info;

	// scoreboard state kept by the monitor.
	micro_instr_t         sent_q[$];
	iorder_info_t         commit_q[$];
	logic [TAG_W-1:0]     commit_tag_q[$];
	logic [TAG_W-1:0]     issue_tag_log[$];
	logic [IORDER_DP-1:0] completed;
	logic [TAG_W-1:0]     exp_tag;
	int                   n_accepted;
	int                   n_issued;
	int                   n_committed;
	micro_instr_t         exp_instr;
	iorder_info_t         exp_info;
	logic [TAG_W-1:0]     exp_commit_tag;

	logic [TAG_W-1:0]     pending_tags[$]; // issued, not yet completed.
	int                   log_rd;

	dispatch_top #(.DP(DP), .IORDER_DP(IORDER_DP)) dut0 (
		.CLK(CLK), .rst(rst),
		.in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
		.issue_valid(issue_valid), .issue_ready(issue_ready), .issue_info(issue_info),
		.complete_valid(complete_valid), .complete_tag(complete_tag),
		.commit_valid(commit_valid), .commit_info(commit_info)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic print_fail_message();
		$display("CHECKS FAILED");
	endtask

	task automatic report_mismatch(input string msg);
		$display("FAIL at %0t: %s", $time, msg);
		print_fail_message();
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		print_fail_message();
		$fatal(1, "stopped at the first error");
	endtask

	// reference issue classes.
	function automatic unit_e ref_unit(input op_e op);
		if (op inside {OP_LUI, OP_AUIPC, OP_ADDI, OP_ADDIW, OP_ADD, OP_ADDW, OP_SUB, OP_SUBW})
			return UNIT_ADDER;
		if (op inside {OP_SLTI, OP_SLTIU, OP_SLT, OP_SLTU, OP_XORI, OP_ORI, OP_ANDI,
				OP_XOR, OP_OR, OP_AND})
			return UNIT_LOGCMP;
		if (op inside {OP_SLLI, OP_SLLIW, OP_SRLI, OP_SRLIW, OP_SRAI, OP_SRAIW,
				OP_SLL, OP_SLLW, OP_SRL, OP_SRLW, OP_SRA, OP_SRAW})
			return UNIT_SHIFT;
		if (op inside {OP_JAL, OP_JALR}) return UNIT_JAL;
		if (op inside {[OP_BEQ:OP_BGEU]}) return UNIT_BRU;
		if (op inside {[OP_LB:OP_LWU]}) return UNIT_LU;
		if (op inside {[OP_SB:OP_SD]}) return UNIT_SU;
		if (op inside {[OP_CSRRW:OP_CSRRCI]}) return UNIT_CSR;
		if (op inside {OP_FENCE, OP_FENCE_I}) return UNIT_FENCE;
		return UNIT_OTH; // ecall, ebreak.
	endfunction

	function automatic logic [UNIT_NUM-1:0] unit_bit(input op_e op);
		logic [UNIT_NUM-1:0] b;
		b = '0;
		b[ref_unit(op)] = 1'b1;
		return b;
	endfunction

	function automatic iorder_info_t info_of(input micro_instr_t mi);
		iorder_info_t info;
		unit_e        u;
		u = ref_unit(mi.op);
		info.pc        = mi.pc;
		info.rd0       = mi.rd0;
		info.is_branch = (u == UNIT_JAL) || (u == UNIT_BRU);
		info.is_sys    = (u == UNIT_CSR) || (u == UNIT_FENCE) || (u == UNIT_OTH);
		return info;
	endfunction

	function automatic micro_instr_t make_instr(input op_e op);
		micro_instr_t mi;
		mi.op     = op;
		mi.pc     = {$urandom, $urandom} & ~64'h3;
		mi.imm    = {$urandom, $urandom};
		mi.shamt  = 6'($urandom);
		mi.rd0    = REG_W'($urandom);
		mi.rs1    = REG_W'($urandom);
		mi.rs2    = REG_W'($urandom);
		mi.is_rvc = 1'($urandom);
		return mi;
	endfunction

	function automatic op_e random_op();
		op_e probe;
		return op_e'(6'($urandom % probe.num()));
	endfunction

	function automatic logic [UNIT_NUM-1:0] random_ready();
		logic [UNIT_NUM-1:0] r;
		for (int i = 0; i < UNIT_NUM; i++)
			r[i] = ($urandom % 4) != 0; // ready three cycles in four.
		return r;
	endfunction

	// sampled on the falling edge before each transfer edge.
	always @(negedge CLK) begin
		if (rst) begin
			n_accepted  = 0;
			n_issued    = 0;
			n_committed = 0;
			completed   = '0;
			exp_tag     = '0;
		end else begin
			if (issue_valid != '0) begin
				assert (sent_q.size() > 0 && issue_valid == unit_bit(sent_q[0].op)) else
					report_mismatch($sformatf("issue_valid %b for op %s",
						issue_valid, sent_q[0].op.name()));
			end
			if ((issue_valid & issue_ready) != '0) begin
				exp_instr = sent_q.pop_front();
				assert (issue_info.instr == exp_instr) else
					report_mismatch($sformatf("payload of %s differs from the one sent",
						exp_instr.op.name()));
				assert (issue_info.tag == exp_tag) else
					report_mismatch($sformatf("tag %0d, expected %0d", issue_info.tag, exp_tag));
				commit_q.push_back(info_of(exp_instr));
				commit_tag_q.push_back(exp_tag);
				issue_tag_log.push_back(exp_tag);
				exp_tag = TAG_W'((int'(exp_tag) + 1) % IORDER_DP);
				n_issued++;
			end
			if (commit_valid) begin
				assert (commit_q.size() > 0) else
					report_problem("a commit came out with no instruction outstanding");
				exp_info = commit_q.pop_front();
				exp_commit_tag = commit_tag_q.pop_front();
				assert (commit_info == exp_info) else
					report_mismatch($sformatf("commit pc %h rd0 %0d, expected pc %h rd0 %0d",
						commit_info.pc, commit_info.rd0, exp_info.pc, exp_info.rd0));
				assert (completed[exp_commit_tag]) else
					report_problem("an instruction retired before it was completed");
				completed[exp_commit_tag] = 1'b0;
				n_committed++;
			end
			if (complete_valid) completed[complete_tag] = 1'b1;
			if (in_valid && in_ready) begin
				sent_q.push_back(in_instr);
				n_accepted++;
			end
		end
	end

	task automatic next_slot();
		@(posedge CLK);
		#2;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) next_slot();
	endtask

	task automatic wait_issued(input int target);
		while (n_issued < target) next_slot();
	endtask

	task automatic send_instr(input micro_instr_t mi);
		logic taken;
		in_valid = 1'b1;
		in_instr = mi;
		do begin
			@(negedge CLK);
			taken = in_ready;
			next_slot();
		end while (!taken);
		in_valid = 1'b0;
	endtask

	task automatic collect_tags();
		while (log_rd < issue_tag_log.size()) begin
			pending_tags.push_back(issue_tag_log[log_rd]);
			log_rd++;
		end
	endtask

	task automatic complete_one(input logic [TAG_W-1:0] t);
		complete_valid = 1'b1;
		complete_tag   = t;
		next_slot();
		complete_valid = 1'b0;
	endtask

	// completes random outstanding tags until the first target issues are all done.
	task automatic run_completer(input int target, input int pct);
		int idx;
		while (n_issued < target || log_rd < issue_tag_log.size()
				|| pending_tags.size() > 0) begin
			collect_tags();
			complete_valid = 1'b0;
			if (pending_tags.size() > 0 && ($urandom % 100) < pct) begin
				idx = int'($urandom % pending_tags.size());
				complete_valid = 1'b1;
				complete_tag   = pending_tags[idx];
				pending_tags.delete(idx);
			end
			next_slot();
		end
		complete_valid = 1'b0;
	endtask

	task automatic drain();
		issue_ready = '1;
		run_completer(n_accepted, 100);
		while (n_committed < n_accepted) next_slot();
	endtask

	task automatic check_reset_state();
		assert (in_ready && issue_valid == '0 && !commit_valid) else
			report_mismatch($sformatf("after reset in_ready %b issue_valid %b commit_valid %b",
				in_ready, issue_valid, commit_valid));
	endtask

	task automatic test_routing();
		op_e op;
		int  target;
		issue_ready = '1;
		target = n_issued + op.num();
		fork
			begin
				op = op.first();
				repeat (op.num()) begin
					send_instr(make_instr(op));
					op = op.next();
				end
			end
			run_completer(target, 100);
		join
	endtask

	task automatic test_in_order();
		op_e              mix [IORDER_DP];
		logic [TAG_W-1:0] t;
		int               base_i;
		int               j;
		mix = '{OP_ADD, OP_JAL, OP_BEQ, OP_CSRRW, OP_FENCE, OP_ECALL, OP_LD, OP_SD};
		issue_ready = '1;
		base_i = n_issued;
		for (int i = 0; i < IORDER_DP; i++)
			send_instr(make_instr(mix[i]));
		wait_issued(base_i + IORDER_DP);
		collect_tags();
		for (int i = IORDER_DP - 1; i > 0; i--) begin
			j = int'($urandom % (i + 1));
			t = pending_tags[i];
			pending_tags[i] = pending_tags[j];
			pending_tags[j] = t;
		end
		while (pending_tags.size() > 0)
			complete_one(pending_tags.pop_front());
		drain();
	endtask

	task automatic test_unit_backpressure();
		int base_i;
		issue_ready = '1;
		issue_ready[UNIT_LU] = 1'b0; // load unit busy.
		base_i = n_issued;
		for (int i = 0; i < DP; i++)
			send_instr(make_instr(op_e'(int'(OP_LB) + i)));
		wait_cycles(3);
		assert (!in_ready && n_issued == base_i && issue_valid[UNIT_LU]) else
			report_mismatch($sformatf("held load unit: in_ready %b, %0d issued",
				in_ready, n_issued - base_i));
		issue_ready[UNIT_LU] = 1'b1;
		wait_issued(base_i + DP);
		drain();
	endtask

	task automatic test_buffer_full();
		int base_i;
		issue_ready = '1;
		base_i = n_issued;
		repeat (IORDER_DP + 2) send_instr(make_instr(random_op()));
		wait_cycles(3);
		assert (n_issued == base_i + IORDER_DP && issue_valid == '0) else
			report_mismatch($sformatf("%0d issued into a full buffer", n_issued - base_i));
		collect_tags();
		complete_one(pending_tags.pop_front()); // oldest.
		wait_cycles(4);
		assert (n_issued == base_i + IORDER_DP + 1) else
			report_mismatch($sformatf("%0d issued after one retirement, expected %0d",
				n_issued - base_i, IORDER_DP + 1));
		drain();
	endtask

	task automatic test_random_mix();
		int base_i;
		int base_c;
		base_i = n_issued;
		base_c = n_committed;
		fork
			repeat (N_RANDOM) send_instr(make_instr(random_op()));
			run_completer(base_i + N_RANDOM, 70);
			begin
				while (n_issued < base_i + N_RANDOM) begin
					issue_ready = random_ready();
					next_slot();
				end
				issue_ready = '1;
			end
		join
		wait_cycles(IORDER_DP + 2); // completed entries retire one per cycle.
		assert (n_committed - base_c == N_RANDOM && !commit_valid) else
			report_mismatch($sformatf("%0d committed of %0d sent",
				n_committed - base_c, N_RANDOM));
	endtask

	initial begin
		void'($urandom(32'hc5c3_69f3));
		rst            = 1'b1;
		in_valid       = 1'b0;
		in_instr       = '0;
		issue_ready    = '0;
		complete_valid = 1'b0;
		complete_tag   = '0;
		log_rd         = 0;
		repeat (3) @(posedge CLK);
		#2;
		rst = 1'b0;
		check_reset_state();
		test_routing();
		test_in_order();
		test_unit_backpressure();
		test_buffer_full();
		test_random_mix();
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		report_problem("simulation timed out before the tests finished");
	end

endmodule

/* hw/dispatch_top.sv */
/* dispatch_top
 * dispatch fifo, issue steering and in-order buffer of the rv64i dispatch stage. */

`timescale 1ns/1ps

module dispatch_top import dispatch_pkg::*; #(
	parameter int DP        = 4,
	parameter int IORDER_DP = 8
) (
	input  logic                CLK,
	input  logic                rst,

	input  logic                in_valid,
	output logic                in_ready,
	input  micro_instr_t        in_instr,

	output logic [UNIT_NUM-1:0] issue_valid,
	input  logic [UNIT_NUM-1:0] issue_ready,
	output issue_info_t         issue_info,

	input  logic                complete_valid,
	input  logic [TAG_W-1:0]    complete_tag,

	output logic                commit_valid,
	output iorder_info_t        commit_info
);

	logic             fifo_valid;
	logic             fifo_ready;
	micro_instr_t     fifo_instr;

	logic             push_valid;
	logic             push_ready;
	iorder_info_t     push_info;
	logic [TAG_W-1:0] push_tag;

	gen_fifo #(
		.DP(DP),
		.DW($bits(micro_instr_t))
	) dispatch_fifo (
		.CLK     (CLK),
		.rst     (rst),
		.valid_a (in_valid),
		.ready_a (in_ready),
		.data_a  (in_instr),
		.valid_b (fifo_valid),
		.ready_b (fifo_ready),
		.data_b  (fifo_instr)
	);

	dispatch dispatch0 (
		.fifo_valid  (fifo_valid),
		.fifo_ready  (fifo_ready),
		.fifo_instr  (fifo_instr),
		.push_valid  (push_valid),
		.push_ready  (push_ready),
		.push_tag    (push_tag),
		.push_info   (push_info),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue_info  (issue_info)
	);

	iorder_buffer #(
		.IORDER_DP(IORDER_DP)
	) iorder0 (
		.CLK            (CLK),
		.rst            (rst),
		.push_valid     (push_valid),
		.push_ready     (push_ready),
		.push_info      (push_info),
		.push_tag       (push_tag),
		.complete_valid (complete_valid),
		.complete_tag   (complete_tag),
		.commit_valid   (commit_valid),
		.commit_info    (commit_info)
	);

endmodule

/* hw/iorder_buffer.sv */
/* iorder_buffer
 * hands out tags, takes completions in any order, retires in program order. */

`timescale 1ns/1ps

module iorder_buffer import dispatch_pkg::*; #(
	parameter int IORDER_DP = 8 // up to 8.
) (
	input  logic             CLK,
	input  logic             rst,

	input  logic             push_valid,
	output logic             push_ready,
	input  iorder_info_t     push_info,
	output logic [TAG_W-1:0] push_tag,

	input  logic             complete_valid,
	input  logic [TAG_W-1:0] complete_tag,

	output logic             commit_valid,
	output iorder_info_t     commit_info
);

	localparam logic [TAG_W-1:0] LAST_IDX = TAG_W'(IORDER_DP - 1);
	localparam logic [TAG_W:0]   FULL_CNT = (TAG_W + 1)'(IORDER_DP);

	iorder_info_t           info_q [IORDER_DP];
	logic [IORDER_DP-1:0]   done;
	logic [TAG_W-1:0]       head;
	logic [TAG_W-1:0]       tail; // next tag.
	logic [TAG_W:0]         count;
	logic                   push_fire;
	logic                   commit_fire;

	function automatic logic [TAG_W-1:0] ptr_inc(input logic [TAG_W-1:0] p);
		return (p == LAST_IDX) ? '0 : p + 1'b1;
	endfunction

	assign push_ready   = (count != FULL_CNT);
	assign push_tag     = tail;
	assign commit_valid = (count != '0) && done[head];
	assign commit_info  = info_q[head];

	assign push_fire   = push_valid & push_ready;
	assign commit_fire = commit_valid; // nothing stalls retirement.

	always_ff @(posedge CLK) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (commit_fire) begin
				done[head] <= 1'b0;
				head       <= ptr_inc(head);
			end
			if (push_fire) begin
				done[tail] <= 1'b0;
				tail       <= ptr_inc(tail);
			end
			if (complete_valid) begin
				done[complete_tag] <= 1'b1;
			end

			case ({push_fire, commit_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// entry payload.
	always_ff @(posedge CLK) begin
		if (push_fire) begin
			info_q[tail] <= push_info;
		end
	end

endmodule

/* hw/dispatch.sv */
/* dispatch
 * steers the fifo head to its issue port and pushes it into the in-order buffer. */

`timescale 1ns/1ps

module dispatch import dispatch_pkg::*; (
	input  logic                fifo_valid,
	output logic                fifo_ready,
	input  micro_instr_t        fifo_instr,

	output logic                push_valid,
	input  logic                push_ready,
	input  logic [TAG_W-1:0]    push_tag,
	output iorder_info_t        push_info,

	output logic [UNIT_NUM-1:0] issue_valid,
	input  logic [UNIT_NUM-1:0] issue_ready,
	output issue_info_t         issue_info
);

	unit_e               unit;
	logic [UNIT_NUM-1:0] unit_sel; // one-hot of unit.
	logic                sel_ready;
	logic                head_ok;

	// opcode to issue class.
	always_comb begin
		case (fifo_instr.op)
			OP_LUI, OP_AUIPC,
			OP_ADDI, OP_ADDIW, OP_ADD, OP_ADDW,
			OP_SUB, OP_SUBW:
				unit = UNIT_ADDER;

			OP_SLTI, OP_SLTIU, OP_SLT, OP_SLTU,
			OP_XORI, OP_ORI, OP_ANDI,
			OP_XOR, OP_OR, OP_AND:
				unit = UNIT_LOGCMP;

			OP_SLLI, OP_SLLIW, OP_SLL, OP_SLLW,
			OP_SRLI, OP_SRLIW, OP_SRL, OP_SRLW,
			OP_SRAI, OP_SRAIW, OP_SRA, OP_SRAW:
				unit = UNIT_SHIFT;

			OP_JAL, OP_JALR:
				unit = UNIT_JAL;

			OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
				unit = UNIT_BRU;

			OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU:
				unit = UNIT_LU;

			OP_SB, OP_SH, OP_SW, OP_SD:
				unit = UNIT_SU;

			OP_CSRRW, OP_CSRRS, OP_CSRRC,
			OP_CSRRWI, OP_CSRRSI, OP_CSRRCI:
				unit = UNIT_CSR;

			OP_FENCE, OP_FENCE_I:
				unit = UNIT_FENCE;

			default:
				unit = UNIT_OTH; // ecall, ebreak.
		endcase
	end

	assign unit_sel  = UNIT_NUM'(1) << unit;
	assign sel_ready = |(issue_ready & unit_sel);

	// a tag must be free before anything is offered.
	assign head_ok = fifo_valid & push_ready;

	assign issue_valid = head_ok ? unit_sel : '0;
	assign push_valid  = head_ok & sel_ready;
	assign fifo_ready  = push_ready & sel_ready; // pop with the issue.

	assign issue_info.instr = fifo_instr;
	assign issue_info.tag   = push_tag;

	assign push_info.pc        = fifo_instr.pc;
	assign push_info.rd0       = fifo_instr.rd0;
	assign push_info.is_branch = (unit == UNIT_JAL) || (unit == UNIT_BRU);
	assign push_info.is_sys    = (unit == UNIT_CSR) || (unit == UNIT_FENCE)
		|| (unit == UNIT_OTH);

endmodule

/* hw/gen_fifo.sv */
/* gen_fifo
 * register-array fifo with a valid/ready handshake on both sides. */

`timescale 1ns/1ps

module gen_fifo #(
	parameter int DP = 4, // power of two.
	parameter int DW = 32
) (
	input  logic          CLK,
	input  logic          rst,

	input  logic          valid_a,
	output logic          ready_a,
	input  logic [DW-1:0] data_a,

	output logic          valid_b,
	input  logic          ready_b,
	output logic [DW-1:0] data_b
);

	localparam int AW = $clog2(DP);

	logic [DW-1:0] buf_q [DP];
	logic [AW:0]   wr_ptr; // extra bit tells full from empty.
	logic [AW:0]   rd_ptr;
	logic          full;
	logic          empty;
	logic          wr_en;
	logic          rd_en;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign ready_a = ~full;
	assign valid_b = ~empty;
	assign data_b  = buf_q[rd_ptr[AW-1:0]];

	assign wr_en = valid_a & ready_a;
	assign rd_en = valid_b & ready_b;

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) wr_ptr <= wr_ptr + 1'b1;
			if (rd_en) rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			buf_q[wr_ptr[AW-1:0]] <= data_a;
		end
	end

endmodule

/* hw/dispatch_pkg.sv */
/* dispatch_pkg
 * opcode and issue-class enums, widths and packed payloads for the dispatch stage. */

package dispatch_pkg;

	localparam int RNBIT = 2; // rename bits per arch register.
	localparam int REG_W = 5 + RNBIT;
	localparam int TAG_W = 3; // covers in-order depth up to 8.

	// rv64i reference set.
	typedef enum logic [5:0] {
		OP_LUI, OP_AUIPC,

		OP_JAL, OP_JALR,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,

		OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
		OP_SB, OP_SH, OP_SW, OP_SD,

		OP_ADDI, OP_ADDIW, OP_SLTI, OP_SLTIU,
		OP_XORI, OP_ORI, OP_ANDI,
		OP_SLLI, OP_SLLIW, OP_SRLI, OP_SRLIW, OP_SRAI, OP_SRAIW,

		OP_ADD, OP_ADDW, OP_SUB, OP_SUBW,
		OP_SLL, OP_SLLW, OP_SLT, OP_SLTU, OP_XOR,
		OP_SRL, OP_SRLW, OP_SRA, OP_SRAW, OP_OR, OP_AND,

		OP_FENCE, OP_FENCE_I,
		OP_ECALL, OP_EBREAK,
		OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI
	} op_e;

	// issue classes, one port each.
	typedef enum logic [3:0] {
		UNIT_ADDER,
		UNIT_LOGCMP,
		UNIT_SHIFT,
		UNIT_JAL,
		UNIT_BRU,
		UNIT_LU,
		UNIT_SU,
		UNIT_CSR,
		UNIT_FENCE,
		UNIT_OTH
	} unit_e;

	localparam int UNIT_NUM = 10;

	typedef struct packed {
		op_e              op;
		logic [63:0]      pc;
		logic [63:0]      imm;
		logic [5:0]       shamt;
		logic [REG_W-1:0] rd0;
		logic [REG_W-1:0] rs1;
		logic [REG_W-1:0] rs2;
		logic             is_rvc; // carried only.
	} micro_instr_t;

	typedef struct packed {
		micro_instr_t     instr;
		logic [TAG_W-1:0] tag;
	} issue_info_t;

	/* what the in-order buffer keeps per entry */
	typedef struct packed {
		logic [63:0]      pc;
		logic [REG_W-1:0] rd0;
		logic             is_branch; // jal, jalr and branches.
		logic             is_sys;    // csr, fence, ecall/ebreak.
	} iorder_info_t;

endpackage
